//--- rename_freelist.f
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/rename_ctrl.sv
verilog/rename_top.sv
sim/clk_gen.sv
sim/tb_rename.sv

//--- run_sim.sh
#!/bin/sh
# build and run tb_rename with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_rename

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_rename -f rename_freelist.f -o tb_rename
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

//--- sim/tb_rename.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename;
    import rename_pkg::*;

    typedef struct packed {
        logic                     rdy;
        ren_rsp_t [REN_WIDTH-1:0] rsp;
    } expect_t;

    wire           clk;
    wire           rst;
    ren_req_t      ren [REN_WIDTH];
    cmt_t          cmt [CMT_WIDTH];
    logic          flush;
    wire           ren_rdy;
    wire ren_rsp_t rsp [REN_WIDTH];

    // model state
    preg_t spec_map [ARCH_REGS];
    preg_t arch_map [ARCH_REGS];
    // free registers from the architectural head on, spec_off is the speculative head
    preg_t free_q [$];
    int    spec_off;
    // oldest first, stands in for the ROB
    cmt_t  inflight [$];

    logic last_stall;
    int   err_count;
    int   check_count;
    int   stall_cycles;
    int   flush_count;
    int   cycle_count;
    int   phase_len;
    int   cycle_limit;

    clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rename_top i_rename_top (
        .clk       (clk),
        .i_rst     (rst),
        .i_ren     (ren),
        .i_cmt     (cmt),
        .i_flush   (flush),
        .o_ren_rdy (ren_rdy),
        .o_ren_rsp (rsp)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // expected ready and responses from the model state
    function automatic expect_t predict(input ren_req_t [REN_WIDTH-1:0] grp);
        expect_t e;
        int      lane;
        int      idx;
        e    = '0;
        lane = 0;
        for (int s = 0; s < REN_WIDTH; s++) begin
            e.rsp[s].prs1    = spec_map[grp[s].rs1];
            e.rsp[s].prs2    = spec_map[grp[s].rs2];
            e.rsp[s].old_prd = spec_map[grp[s].rd];
            for (int j = 0; j < s; j++) begin
                if (grp[j].valid && grp[j].we) begin
                    if (grp[j].rd == grp[s].rs1) begin
                        e.rsp[s].prs1 = e.rsp[j].prd;
                    end
                    if (grp[j].rd == grp[s].rs2) begin
                        e.rsp[s].prs2 = e.rsp[j].prd;
                    end
                    if (grp[j].rd == grp[s].rd) begin
                        e.rsp[s].old_prd = e.rsp[j].prd;
                    end
                end
            end
            if (grp[s].valid && grp[s].we) begin
                idx = spec_off + lane;
                if (idx < free_q.size()) begin
                    e.rsp[s].prd = free_q[idx];
                end
                lane++;
            end
        end
        e.rdy = (free_q.size() - spec_off) >= lane;
        return e;
    endfunction

    // model across the next rising edge
    function automatic void apply_edge(input expect_t e);
        int   n;
        cmt_t ent;
        n = 0;
        for (int c = 0; c < CMT_WIDTH; c++) begin
            if (cmt[c].valid) begin
                arch_map[cmt[c].rd] = cmt[c].prd;
                free_q.push_back(cmt[c].old_prd);
                n++;
            end
        end
        for (int c = 0; c < n; c++) begin
            void'(free_q.pop_front());
            void'(inflight.pop_front());
        end
        spec_off = spec_off - n;
        if (flush) begin
            spec_map = arch_map;
            spec_off = 0;
            inflight.delete();
            flush_count++;
        end else if (e.rdy) begin
            for (int s = 0; s < REN_WIDTH; s++) begin
                if (ren[s].valid && ren[s].we) begin
                    spec_map[ren[s].rd] = e.rsp[s].prd;
                    spec_off++;
                    ent.valid   = 1'b1;
                    ent.rd      = ren[s].rd;
                    ent.prd     = e.rsp[s].prd;
                    ent.old_prd = e.rsp[s].old_prd;
                    inflight.push_back(ent);
                end
            end
        end
    endfunction

    task automatic drive_cycle(input int phase, input int step);
        ren_req_t req;
        int       n_cmt;
        int       span;
        int       single;
        // small register range in phase 2 so groups collide often
        span   = (phase == 2) ? 4 : ARCH_REGS;
        single = int'($urandom % 2);
        if (!last_stall) begin
            for (int s = 0; s < REN_WIDTH; s++) begin
                req       = '0;
                req.rd    = areg_t'($urandom % span);
                req.rs1   = areg_t'($urandom % span);
                req.rs2   = areg_t'($urandom % span);
                req.valid = ($urandom % 4) != 0;
                req.we    = ($urandom % 4) != 0;
                if (phase == 1) begin
                    req.valid = req.valid && (s == single);
                    req.we    = 1'b1;
                end else if (phase == 3) begin
                    req.valid = 1'b1;
                    req.we    = ($urandom % 8) != 0;
                end
                ren[s] <= req;
            end
        end
        n_cmt = int'($urandom % 3);
        // commits pause for most of each round so the free list drains
        if (phase == 3 && (step % 120) < 80) begin
            n_cmt = 0;
        end
        if (n_cmt > inflight.size()) begin
            n_cmt = inflight.size();
        end
        for (int c = 0; c < CMT_WIDTH; c++) begin
            if (c < n_cmt) begin
                cmt[c] <= inflight[c];
            end else begin
                cmt[c] <= '0;
            end
        end
        // lone commit sometimes in slot 1
        if (n_cmt == 1 && ($urandom % 2) == 1) begin
            cmt[0] <= '0;
            cmt[1] <= inflight[0];
        end
        flush <= (phase == 4) && (($urandom % 25) == 0);
    endtask

    always @(negedge clk) begin : compare_proc
        expect_t e;
        if (rst === 1'b0) begin
            e = predict({ren[1], ren[0]});
            check_value("o_ren_rdy", 32'(ren_rdy), 32'(e.rdy));
            if (!e.rdy) begin
                stall_cycles++;
            end
            if (e.rdy && !flush) begin
                for (int s = 0; s < REN_WIDTH; s++) begin
                    if (ren[s].valid) begin
                        check_value($sformatf("slot %0d prs1", s),
                                    32'(rsp[s].prs1), 32'(e.rsp[s].prs1));
                        check_value($sformatf("slot %0d prs2", s),
                                    32'(rsp[s].prs2), 32'(e.rsp[s].prs2));
                    end
                    if (ren[s].valid && ren[s].we) begin
                        check_value($sformatf("slot %0d prd", s),
                                    32'(rsp[s].prd), 32'(e.rsp[s].prd));
                        check_value($sformatf("slot %0d old_prd", s),
                                    32'(rsp[s].old_prd), 32'(e.rsp[s].old_prd));
                    end
                end
            end
            last_stall = !e.rdy && !flush;
            apply_edge(e);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, stimulus never finished", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h9c1aa562));
        err_count    = 0;
        check_count  = 0;
        stall_cycles = 0;
        flush_count  = 0;
        cycle_count  = 0;
        phase_len    = 600;
        // four phases plus reset and margin
        cycle_limit  = 5 * phase_len;
        last_stall   = 1'b0;
        flush        = 1'b0;
        for (int s = 0; s < REN_WIDTH; s++) begin
            ren[s] = '0;
        end
        for (int c = 0; c < CMT_WIDTH; c++) begin
            cmt[c] = '0;
        end
        for (int r = 0; r < ARCH_REGS; r++) begin
            spec_map[r] = preg_t'(r);
            arch_map[r] = preg_t'(r);
        end
        for (int f = 0; f < FREE_DEPTH; f++) begin
            free_q.push_back(preg_t'(ARCH_REGS + f));
        end
        spec_off = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
        end
        for (int phase = 1; phase <= 4; phase++) begin
            for (int step = 0; step < phase_len; step++) begin
                @(posedge clk);
                drive_cycle(phase, step);
            end
        end
        @(posedge clk);
        flush <= 1'b0;
        for (int s = 0; s < REN_WIDTH; s++) begin
            ren[s] <= '0;
        end
        for (int c = 0; c < CMT_WIDTH; c++) begin
            cmt[c] <= '0;
        end
        repeat (2) @(posedge clk);
        if (stall_cycles == 0) begin
            $display("the free list never ran short, exhaustion was not exercised");
            err_count++;
        end
        if (flush_count == 0) begin
            $display("no flush was issued during the run");
            err_count++;
        end
        $display("checks %0d, errors %0d, stall cycles %0d, flushes %0d",
                 check_count, err_count, stall_cycles, flush_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic o_clk,
    output logic o_rst
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

    initial begin
        o_rst = 1'b1;
        repeat (16) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/rename_top.sv
`timescale 1ns/100ps
`default_nettype none

module rename_top (
    input  wire                            clk,
    input  wire                            i_rst,
    input  wire rename_pkg::ren_req_t      i_ren [rename_pkg::REN_WIDTH],
    input  wire rename_pkg::cmt_t          i_cmt [rename_pkg::CMT_WIDTH],
    input  wire                            i_flush,
    output wire                            o_ren_rdy,
    output wire rename_pkg::ren_rsp_t      o_ren_rsp [rename_pkg::REN_WIDTH]
);
    import rename_pkg::*;

    wire [REN_WIDTH-1:0] can_alloc;
    wire [REN_WIDTH-1:0] alloc_req;
    wire [CMT_WIDTH-1:0] release_req;
    wire [REN_WIDTH-1:0] map_we;
    wire [CMT_WIDTH-1:0] arch_we;
    wire cnt_t           commit_num;
    wire preg_t          free_head [REN_WIDTH];
    wire preg_t          release_preg [CMT_WIDTH];
    wire areg_t          src_areg [SRC_PORTS];
    wire preg_t          src_preg [SRC_PORTS];
    wire areg_t          dst_areg [REN_WIDTH];
    wire preg_t          dst_old [REN_WIDTH];
    wire areg_t          map_rd [REN_WIDTH];
    wire preg_t          map_preg [REN_WIDTH];
    wire areg_t          arch_rd [CMT_WIDTH];
    wire preg_t          arch_preg [CMT_WIDTH];

    // lookup ports, rs1 then rs2 per slot
    generate
        for (genvar s = 0; s < REN_WIDTH; s++) begin : g_lookup
            assign src_areg[2*s]   = i_ren[s].rs1;
            assign src_areg[2*s+1] = i_ren[s].rs2;
            assign dst_areg[s]     = i_ren[s].rd;
        end
    endgenerate

    rename_ctrl u_ctrl (
        .i_ren          (i_ren),
        .i_cmt          (i_cmt),
        .i_flush        (i_flush),
        .i_can_alloc    (can_alloc),
        .i_free_head    (free_head),
        .i_spec_src     (src_preg),
        .i_spec_old     (dst_old),
        .o_ren_rdy      (o_ren_rdy),
        .o_alloc_req    (alloc_req),
        .o_release_req  (release_req),
        .o_release_preg (release_preg),
        .o_commit_num   (commit_num),
        .o_map_we       (map_we),
        .o_map_rd       (map_rd),
        .o_map_preg     (map_preg),
        .o_arch_we      (arch_we),
        .o_arch_rd      (arch_rd),
        .o_arch_preg    (arch_preg),
        .o_ren_rsp      (o_ren_rsp)
    );

    free_list u_free_list (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_flush        (i_flush),
        .i_alloc_req    (alloc_req),
        .o_can_alloc    (can_alloc),
        .o_free_head    (free_head),
        .i_release_req  (release_req),
        .i_release_preg (release_preg),
        .i_commit_num   (commit_num)
    );

    rename_map u_map (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_src_areg  (src_areg),
        .o_src_preg  (src_preg),
        .i_dst_areg  (dst_areg),
        .o_dst_old   (dst_old),
        .i_map_we    (map_we),
        .i_map_rd    (map_rd),
        .i_map_preg  (map_preg),
        .i_arch_we   (arch_we),
        .i_arch_rd   (arch_rd),
        .i_arch_preg (arch_preg)
    );

endmodule

`default_nettype wire

//--- verilog/rename_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rename_ctrl (
    input  wire rename_pkg::ren_req_t        i_ren [rename_pkg::REN_WIDTH],
    input  wire rename_pkg::cmt_t            i_cmt [rename_pkg::CMT_WIDTH],
    input  wire                              i_flush,
    input  wire [rename_pkg::REN_WIDTH-1:0]  i_can_alloc,
    input  wire rename_pkg::preg_t           i_free_head [rename_pkg::REN_WIDTH],
    input  wire rename_pkg::preg_t           i_spec_src [rename_pkg::SRC_PORTS],
    input  wire rename_pkg::preg_t           i_spec_old [rename_pkg::REN_WIDTH],
    output logic                             o_ren_rdy,
    output logic [rename_pkg::REN_WIDTH-1:0] o_alloc_req,
    output logic [rename_pkg::CMT_WIDTH-1:0] o_release_req,
    output rename_pkg::preg_t                o_release_preg [rename_pkg::CMT_WIDTH],
    output rename_pkg::cnt_t                 o_commit_num,
    output logic [rename_pkg::REN_WIDTH-1:0] o_map_we,
    output rename_pkg::areg_t                o_map_rd [rename_pkg::REN_WIDTH],
    output rename_pkg::preg_t                o_map_preg [rename_pkg::REN_WIDTH],
    output logic [rename_pkg::CMT_WIDTH-1:0] o_arch_we,
    output rename_pkg::areg_t                o_arch_rd [rename_pkg::CMT_WIDTH],
    output rename_pkg::preg_t                o_arch_preg [rename_pkg::CMT_WIDTH],
    output rename_pkg::ren_rsp_t             o_ren_rsp [rename_pkg::REN_WIDTH]
);
    import rename_pkg::*;

    logic [REN_WIDTH-1:0] wr;
    logic [REN_WIDTH-1:0] need;
    logic                 accept;
    preg_t                new_prd [REN_WIDTH];

    // k-th writing slot takes lane k, so need is a prefix mask
    always_comb begin
        int lane;
        lane = 0;
        need = '0;
        for (int s = 0; s < REN_WIDTH; s++) begin
            wr[s]      = i_ren[s].valid & i_ren[s].we;
            new_prd[s] = '0;
            if (wr[s]) begin
                need[lane] = 1'b1;
                new_prd[s] = i_free_head[lane];
                lane       = lane + 1;
            end
        end
    end

    // all or nothing
    assign o_ren_rdy   = &(i_can_alloc | ~need);
    assign accept      = o_ren_rdy & ~i_flush;
    assign o_alloc_req = accept ? need : '0;

    always_comb begin
        for (int s = 0; s < REN_WIDTH; s++) begin
            o_map_we[s]   = accept & wr[s];
            o_map_rd[s]   = i_ren[s].rd;
            o_map_preg[s] = new_prd[s];
        end
    end

    // older slots in the same group override the map lookups
    always_comb begin
        for (int s = 0; s < REN_WIDTH; s++) begin
            o_ren_rsp[s].prs1    = i_spec_src[2*s];
            o_ren_rsp[s].prs2    = i_spec_src[2*s+1];
            o_ren_rsp[s].prd     = new_prd[s];
            o_ren_rsp[s].old_prd = i_spec_old[s];
            for (int j = 0; j < REN_WIDTH; j++) begin
                if (j < s && wr[j]) begin
                    if (i_ren[j].rd == i_ren[s].rs1) begin
                        o_ren_rsp[s].prs1 = new_prd[j];
                    end
                    if (i_ren[j].rd == i_ren[s].rs2) begin
                        o_ren_rsp[s].prs2 = new_prd[j];
                    end
                    if (wr[s] && i_ren[j].rd == i_ren[s].rd) begin
                        o_ren_rsp[s].old_prd = new_prd[j];
                    end
                end
            end
        end
    end

    // commits packed into release lanes in order
    always_comb begin
        int lane;
        lane = 0;
        o_release_req = '0;
        o_commit_num  = '0;
        for (int c = 0; c < CMT_WIDTH; c++) begin
            o_release_preg[c] = '0;
        end
        for (int c = 0; c < CMT_WIDTH; c++) begin
            o_arch_we[c]   = i_cmt[c].valid;
            o_arch_rd[c]   = i_cmt[c].rd;
            o_arch_preg[c] = i_cmt[c].prd;
            if (i_cmt[c].valid) begin
                o_release_req[lane]  = 1'b1;
                o_release_preg[lane] = i_cmt[c].old_prd;
                lane                 = lane + 1;
                o_commit_num         = o_commit_num + cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_map.sv
`timescale 1ns/100ps
`default_nettype none

module rename_map (
    input  wire                             clk,
    input  wire                             i_rst,
    input  wire                             i_flush,
    // lookups
    input  wire rename_pkg::areg_t          i_src_areg [rename_pkg::SRC_PORTS],
    output rename_pkg::preg_t               o_src_preg [rename_pkg::SRC_PORTS],
    input  wire rename_pkg::areg_t          i_dst_areg [rename_pkg::REN_WIDTH],
    output rename_pkg::preg_t               o_dst_old [rename_pkg::REN_WIDTH],
    // speculative writes
    input  wire [rename_pkg::REN_WIDTH-1:0] i_map_we,
    input  wire rename_pkg::areg_t          i_map_rd [rename_pkg::REN_WIDTH],
    input  wire rename_pkg::preg_t          i_map_preg [rename_pkg::REN_WIDTH],
    // commit writes
    input  wire [rename_pkg::CMT_WIDTH-1:0] i_arch_we,
    input  wire rename_pkg::areg_t          i_arch_rd [rename_pkg::CMT_WIDTH],
    input  wire rename_pkg::preg_t          i_arch_preg [rename_pkg::CMT_WIDTH]
);
    import rename_pkg::*;

    preg_t spec_map [ARCH_REGS];
    preg_t arch_map [ARCH_REGS];
    preg_t arch_nxt [ARCH_REGS];

    generate
        for (genvar p = 0; p < SRC_PORTS; p++) begin : g_src
            assign o_src_preg[p] = spec_map[i_src_areg[p]];
        end
        for (genvar s = 0; s < REN_WIDTH; s++) begin : g_old
            assign o_dst_old[s] = spec_map[i_dst_areg[s]];
        end
    endgenerate

    // younger commit wins on the same rd
    always_comb begin
        arch_nxt = arch_map;
        for (int c = 0; c < CMT_WIDTH; c++) begin
            if (i_arch_we[c]) begin
                arch_nxt[i_arch_rd[c]] = i_arch_preg[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                spec_map[r] <= preg_t'(r);
                arch_map[r] <= preg_t'(r);
            end
        end else begin
            arch_map <= arch_nxt;
            if (i_flush) begin
                spec_map <= arch_nxt;
            end else begin
                for (int s = 0; s < REN_WIDTH; s++) begin
                    if (i_map_we[s]) begin
                        spec_map[i_map_rd[s]] <= i_map_preg[s];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/free_list.sv
`timescale 1ns/100ps
`default_nettype none

module free_list (
    input  wire                                 clk,
    input  wire                                 i_rst,
    input  wire                                 i_flush,
    // dequeue side
    input  wire [rename_pkg::REN_WIDTH-1:0]     i_alloc_req,
    output logic [rename_pkg::REN_WIDTH-1:0]    o_can_alloc,
    output rename_pkg::preg_t                   o_free_head [rename_pkg::REN_WIDTH],
    // enqueue side
    input  wire [rename_pkg::CMT_WIDTH-1:0]     i_release_req,
    input  wire rename_pkg::preg_t              i_release_preg [rename_pkg::CMT_WIDTH],
    // architectural advance
    input  wire rename_pkg::cnt_t               i_commit_num
);
    import rename_pkg::*;

    preg_t buffer [FREE_DEPTH];

    // one pointer per lane, wrap is the natural overflow of fptr_t
    fptr_t rd_ptr [REN_WIDTH];
    fptr_t wr_ptr [CMT_WIDTH];
    fptr_t arch_ptr;
    fptr_t arch_ptr_nxt;

    cnt_t count;
    cnt_t arch_count;
    cnt_t arch_count_nxt;
    cnt_t alloc_num;
    cnt_t release_num;

    logic [REN_WIDTH-1:0] alloc_vld;

    assign alloc_vld = i_alloc_req & o_can_alloc;

    always_comb begin
        alloc_num = '0;
        for (int k = 0; k < REN_WIDTH; k++) begin
            if (alloc_vld[k]) begin
                alloc_num = alloc_num + cnt_t'(1);
            end
        end
    end

    always_comb begin
        release_num = '0;
        for (int k = 0; k < CMT_WIDTH; k++) begin
            if (i_release_req[k]) begin
                release_num = release_num + cnt_t'(1);
            end
        end
    end

    // arch state after this edge, also the flush restore point
    assign arch_ptr_nxt   = arch_ptr + fptr_t'(i_commit_num);
    assign arch_count_nxt = arch_count + release_num - i_commit_num;

    generate
        for (genvar k = 0; k < REN_WIDTH; k++) begin : g_head
            assign o_can_alloc[k] = (cnt_t'(k + 1) <= count);
            assign o_free_head[k] = buffer[rd_ptr[k]];
        end
    endgenerate

    // initial contents are the physical registers above the identity map
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int e = 0; e < FREE_DEPTH; e++) begin
                buffer[e] <= preg_t'(ARCH_REGS + e);
            end
        end else begin
            for (int k = 0; k < CMT_WIDTH; k++) begin
                if (i_release_req[k]) begin
                    buffer[wr_ptr[k]] <= i_release_preg[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < CMT_WIDTH; k++) begin
                wr_ptr[k] <= fptr_t'(k);
            end
            arch_ptr   <= '0;
            arch_count <= cnt_t'(FREE_DEPTH);
        end else begin
            for (int k = 0; k < CMT_WIDTH; k++) begin
                wr_ptr[k] <= wr_ptr[k] + fptr_t'(release_num);
            end
            arch_ptr   <= arch_ptr_nxt;
            arch_count <= arch_count_nxt;
        end
    end

    // speculative read side
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < REN_WIDTH; k++) begin
                rd_ptr[k] <= fptr_t'(k);
            end
            count <= cnt_t'(FREE_DEPTH);
        end else if (i_flush) begin
            // drop every speculative allocation
            for (int k = 0; k < REN_WIDTH; k++) begin
                rd_ptr[k] <= arch_ptr_nxt + fptr_t'(k);
            end
            count <= arch_count_nxt;
        end else begin
            for (int k = 0; k < REN_WIDTH; k++) begin
                rd_ptr[k] <= rd_ptr[k] + fptr_t'(alloc_num);
            end
            count <= count + release_num - alloc_num;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int REN_WIDTH  = 2;
    localparam int CMT_WIDTH  = 2;

    // rs1 and rs2 per rename slot
    localparam int SRC_PORTS  = 2 * REN_WIDTH;
    localparam int FREE_PTR_W = $clog2(FREE_DEPTH);

    typedef logic [4:0] areg_t;
    typedef logic [5:0] preg_t;
    typedef logic [5:0] cnt_t;
    typedef logic [FREE_PTR_W-1:0] fptr_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
    } ren_req_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
    } ren_rsp_t;

    // only writing instructions commit here
    typedef struct packed {
        logic  valid;
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
    } cmt_t;

endpackage

`default_nettype wire
